/* Bender.yml */
package:
  name: axil_byte_bridge

sources:
  # Shared package first
  - common/store_pkg.sv
  # Design
  - store_packer/axil_store_packer.sv
  - source/store_queue.sv
  - source/byte_store.sv
  - source/axil_byte_bridge.sv
  # Testbench and assertions
  - target: simulation
    files:
      - sim/axil_bridge_sva.sv
      - sim/tb_axil_byte_bridge.sv

/* common/store_pkg.sv */
//##########################################################################
// Store bridge package
// AXI4-Lite response and protection codes, plus the packed command and
// response formats passed between the packer and the byte memory
//##########################################################################

package store_pkg;

  // Width of the address field carried in a command
  localparam int store_addr_width_c = 23;

  // AXI response codes, only OKAY is ever returned
  typedef enum logic [1:0]
  {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_e;

  // AXI protection type, bit 0 privileged, bit 1 nonsecure, bit 2 instruction
  typedef enum logic [2:0]
  {
    e_axi_prot_data_secure_unpriv = 3'b000,
    e_axi_prot_data_secure_priv   = 3'b001,
    e_axi_prot_data_nonsec_unpriv = 3'b010,
    e_axi_prot_data_nonsec_priv   = 3'b011,
    e_axi_prot_inst_secure_unpriv = 3'b100,
    e_axi_prot_inst_secure_priv   = 3'b101,
    e_axi_prot_inst_nonsec_unpriv = 3'b110,
    e_axi_prot_inst_nonsec_priv   = 3'b111
  } axi_prot_e;

  // Command word, 32 bits in total
  typedef struct packed
  {
    logic                          write_not_read;
    logic [store_addr_width_c-1:0] addr;
    logic [7:0]                    data;
  } store_cmd_s;

  // Read response, one byte
  typedef struct packed
  {
    logic [7:0] data;
  } store_rsp_s;

endpackage

/* sim/axil_bridge_sva.sv */
//##########################################################################
// AXI4-Lite protocol checks on the store packer
//##########################################################################

`timescale 1ns/1ps

module axil_bridge_sva
  (input  logic clk_i
  , input logic reset_i
  , input logic s_axi_awvalid_i
  , input logic s_axi_arvalid_i
  , input logic s_axi_bvalid_o
  , input logic s_axi_bready_i
  , input logic s_axi_rvalid_o
  , input logic s_axi_rready_i
  );

  // Read back by the testbench at the end of the run
  int unsigned failures = 0;

  // Loads and stores are never requested together
  a_no_aw_ar: assert property (@(posedge clk_i) disable iff (reset_i)
    !(s_axi_awvalid_i && s_axi_arvalid_i))
  else
  begin
    failures++;
    $error("awvalid and arvalid high in the same cycle");
  end

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (s_axi_bvalid_o && !s_axi_bready_i) |=> s_axi_bvalid_o)
  else
  begin
    failures++;
    $error("bvalid dropped before bready");
  end

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (s_axi_rvalid_o && !s_axi_rready_i) |=> s_axi_rvalid_o)
  else
  begin
    failures++;
    $error("rvalid dropped before rready");
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> (!s_axi_bvalid_o && !s_axi_rvalid_o))
  else
  begin
    failures++;
    $error("bvalid or rvalid high after reset");
  end

endmodule

bind axil_store_packer axil_bridge_sva sva
  (.clk_i          (clk_i)
  , .reset_i        (reset_i)
  , .s_axi_awvalid_i(s_axi_awvalid_i)
  , .s_axi_arvalid_i(s_axi_arvalid_i)
  , .s_axi_bvalid_o (s_axi_bvalid_o)
  , .s_axi_bready_i (s_axi_bready_i)
  , .s_axi_rvalid_o (s_axi_rvalid_o)
  , .s_axi_rready_i (s_axi_rready_i)
  );

/* sim/bridge_golden.txt */
# Columns: op (W or R), address, wdata, expected rdata, all hex
# Writes ignore the last column, reads ignore wdata
# Reads of untouched bytes return zero after reset
R 00000010 00000000 00000000
R 000000ff 00000000 00000000
# Plain write then read back
W 00000004 000000c3 00000000
R 00000004 00000000 000000c3
# Only the low data byte is kept
W 00000008 123456a5 00000000
R 00000008 00000000 000000a5
W 00000030 ffffff80 00000000
R 00000030 00000000 00000080
# Upper address bits alias modulo 256
W 00000105 0000005a 00000000
R 00000005 00000000 0000005a
R 00000105 00000000 0000005a
W 000007ff 0000003c 00000000
R 000000ff 00000000 0000003c
W 00001000 00000077 00000000
R 00000000 00000000 00000077
# Back to back writes to one byte, the second must win
W 00000020 00000011 00000000
W 00000020 00000022 00000000
R 00000020 00000000 00000022
# Overwrite with zero
W 00000004 00000000 00000000
R 00000004 00000000 00000000
# Neighbours stay untouched
R 00000006 00000000 00000000
R 00000008 00000000 000000a5
W 00000041 abcdef01 00000000
R 00000041 00000000 00000001

/* sim/tb_axil_byte_bridge.sv */
//##########################################################################
// Testbench for the AXI4-Lite byte bridge
// Replays loads and stores from the golden file under random back-pressure
//##########################################################################

`timescale 1ns/1ps

module tb_axil_byte_bridge;

  import store_pkg::*;

  localparam int addr_width_lp    = 32;
  localparam int data_width_lp    = 32;
  localparam int cycles_per_op_lp = 40;

  logic                         clk_i;
  logic                         reset_i;
  logic [addr_width_lp-1:0]     s_axi_awaddr_i;
  axi_prot_e                    s_axi_awprot_i;
  logic                         s_axi_awvalid_i;
  logic                         s_axi_awready_o;
  logic [data_width_lp-1:0]     s_axi_wdata_i;
  logic [(data_width_lp>>3)-1:0] s_axi_wstrb_i;
  logic                         s_axi_wvalid_i;
  logic                         s_axi_wready_o;
  axi_resp_e                    s_axi_bresp_o;
  logic                         s_axi_bvalid_o;
  logic                         s_axi_bready_i;
  logic [addr_width_lp-1:0]     s_axi_araddr_i;
  axi_prot_e                    s_axi_arprot_i;
  logic                         s_axi_arvalid_i;
  logic                         s_axi_arready_o;
  logic [data_width_lp-1:0]     s_axi_rdata_o;
  axi_resp_e                    s_axi_rresp_o;
  logic                         s_axi_rvalid_o;
  logic                         s_axi_rready_i;

  // One entry per golden line
  byte         op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  integer seed         = 70991;
  int     cycle_count  = 0;
  int     limit_cycles = 0;
  int     error_count  = 0;
  int     pass_count   = 0;
  int     fail_count   = 0;

  axil_byte_bridge
    #(.axi_addr_width_p(addr_width_lp)
    , .axi_data_width_p(data_width_lp)
    , .mem_addr_width_p(8)
    )
    dut
    (.clk_i           (clk_i)
    , .reset_i        (reset_i)
    , .s_axi_awaddr_i (s_axi_awaddr_i)
    , .s_axi_awprot_i (s_axi_awprot_i)
    , .s_axi_awvalid_i(s_axi_awvalid_i)
    , .s_axi_awready_o(s_axi_awready_o)
    , .s_axi_wdata_i  (s_axi_wdata_i)
    , .s_axi_wstrb_i  (s_axi_wstrb_i)
    , .s_axi_wvalid_i (s_axi_wvalid_i)
    , .s_axi_wready_o (s_axi_wready_o)
    , .s_axi_bresp_o  (s_axi_bresp_o)
    , .s_axi_bvalid_o (s_axi_bvalid_o)
    , .s_axi_bready_i (s_axi_bready_i)
    , .s_axi_araddr_i (s_axi_araddr_i)
    , .s_axi_arprot_i (s_axi_arprot_i)
    , .s_axi_arvalid_i(s_axi_arvalid_i)
    , .s_axi_arready_o(s_axi_arready_o)
    , .s_axi_rdata_o  (s_axi_rdata_o)
    , .s_axi_rresp_o  (s_axi_rresp_o)
    , .s_axi_rvalid_o (s_axi_rvalid_o)
    , .s_axi_rready_i (s_axi_rready_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Cycle budget, set once the golden file has been read
  initial
  begin
    wait (limit_cycles != 0);
    while (cycle_count < limit_cycles)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles because a transaction never completed",
             cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
  endtask

  // No new request may be taken while a response is pending
  task automatic check_blocked();
    if ({s_axi_awready_o, s_axi_wready_o, s_axi_arready_o} !== 3'b000)
    begin
      report_mismatch("s_axi_awready_o/s_axi_wready_o/s_axi_arready_o", 32'h0,
                      {29'h0, s_axi_awready_o, s_axi_wready_o, s_axi_arready_o});
    end
  endtask

  task automatic load_golden();
    integer          fd;
    integer          code;
    reg [8*128-1:0]  line_buf;
    byte             op;
    logic [31:0]     addr;
    logic [31:0]     data;
    logic [31:0]     expected;
    fd = $fopen("sim/bridge_golden.txt", "r");
    if (fd == 0)
    begin
      error_count++;
      $display("Could not open sim/bridge_golden.txt for reading");
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fscanf(fd, " %c", op);
        if (code == 1)
        begin
          if (op == "#")
          begin
            code = $fgets(line_buf, fd);
          end
          else
          begin
            code = $fscanf(fd, "%h %h %h", addr, data, expected);
            if (code == 3 && (op == "W" || op == "R"))
            begin
              op_q.push_back(op);
              addr_q.push_back(addr);
              data_q.push_back(data);
              exp_q.push_back(expected);
            end
            else
            begin
              error_count++;
              $display("Golden file line %0d could not be parsed", op_q.size() + 1);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Holds bready low for a few cycles after bvalid, then takes the response
  task automatic run_write(input logic [31:0] addr, input logic [31:0] data);
    int hold;
    hold            = $unsigned($random(seed)) % 4;
    s_axi_awaddr_i  = addr;
    s_axi_awprot_i  = axi_prot_e'(3'($random(seed)));
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = 4'($random(seed));
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i  = 1'b1;
    @(negedge clk_i);
    while (!(s_axi_awready_o && s_axi_wready_o))
    begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    @(negedge clk_i);
    while (!s_axi_bvalid_o)
    begin
      check_blocked();
      @(negedge clk_i);
    end
    repeat (hold)
    begin
      @(negedge clk_i);
      check_blocked();
      if (s_axi_bvalid_o !== 1'b1)
      begin
        report_mismatch("s_axi_bvalid_o", 32'h1, {31'h0, s_axi_bvalid_o});
      end
    end
    @(posedge clk_i);
    #1;
    s_axi_bready_i = 1'b1;
    @(negedge clk_i);
    check_blocked();
    if (s_axi_bvalid_o !== 1'b1)
    begin
      report_mismatch("s_axi_bvalid_o", 32'h1, {31'h0, s_axi_bvalid_o});
    end
    if (s_axi_bresp_o !== e_axi_resp_okay)
    begin
      report_mismatch("s_axi_bresp_o", 32'h0, {30'h0, s_axi_bresp_o});
    end
    @(posedge clk_i);
    #1;
    s_axi_bready_i = 1'b0;
  endtask

  task automatic run_read(input logic [31:0] addr, input logic [31:0] expected);
    int hold;
    hold            = $unsigned($random(seed)) % 4;
    s_axi_araddr_i  = addr;
    s_axi_arprot_i  = axi_prot_e'(3'($random(seed)));
    s_axi_arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!s_axi_arready_o)
    begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    s_axi_arvalid_i = 1'b0;
    @(negedge clk_i);
    while (!s_axi_rvalid_o)
    begin
      check_blocked();
      @(negedge clk_i);
    end
    repeat (hold)
    begin
      @(negedge clk_i);
      check_blocked();
      if (s_axi_rvalid_o !== 1'b1)
      begin
        report_mismatch("s_axi_rvalid_o", 32'h1, {31'h0, s_axi_rvalid_o});
      end
    end
    @(posedge clk_i);
    #1;
    s_axi_rready_i = 1'b1;
    @(negedge clk_i);
    check_blocked();
    if (s_axi_rvalid_o !== 1'b1)
    begin
      report_mismatch("s_axi_rvalid_o", 32'h1, {31'h0, s_axi_rvalid_o});
    end
    if (s_axi_rdata_o !== expected)
    begin
      report_mismatch("s_axi_rdata_o", expected, s_axi_rdata_o);
    end
    if (s_axi_rresp_o !== e_axi_resp_okay)
    begin
      report_mismatch("s_axi_rresp_o", 32'h0, {30'h0, s_axi_rresp_o});
    end
    @(posedge clk_i);
    #1;
    s_axi_rready_i = 1'b0;
  endtask

  initial
  begin
    int errors_before;
    reset_i         = 1'b1;
    s_axi_awaddr_i  = '0;
    s_axi_awprot_i  = e_axi_prot_data_secure_unpriv;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b0;
    s_axi_araddr_i  = '0;
    s_axi_arprot_i  = e_axi_prot_data_secure_unpriv;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;

    load_golden();
    if (op_q.size() == 0)
    begin
      error_count++;
      $display("No transactions were read from the golden file");
    end
    limit_cycles = cycles_per_op_lp * op_q.size() + 100;

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    for (int i = 0; i < op_q.size(); i++)
    begin
      errors_before = error_count;
      if (op_q[i] == "W")
      begin
        run_write(addr_q[i], data_q[i]);
      end
      else
      begin
        run_read(addr_q[i], exp_q[i]);
      end
      if (error_count == errors_before)
      begin
        pass_count++;
        $display("test %0d %c addr %h passed", i, op_q[i], addr_q[i]);
      end
      else
      begin
        fail_count++;
        $display("test %0d %c addr %h failed", i, op_q[i], addr_q[i]);
      end
    end

    @(posedge clk_i);
    #1;
    $display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
             op_q.size(), pass_count, fail_count, error_count,
             dut.packer.sva.failures);
    if (error_count == 0 && fail_count == 0 && dut.packer.sva.failures == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* source/axil_byte_bridge.sv */
//##########################################################################
// AXI4-Lite to byte store bridge
// Packer, command and response queues and byte memory
//##########################################################################

`timescale 1ns/1ps

module axil_byte_bridge
  #(parameter int axi_addr_width_p = 32
  , parameter int axi_data_width_p = 32
  , parameter int mem_addr_width_p = 8
  )
  (input  logic                              clk_i
  , input  logic                             reset_i

  , input  logic [axi_addr_width_p-1:0]      s_axi_awaddr_i
  , input  store_pkg::axi_prot_e             s_axi_awprot_i
  , input  logic                             s_axi_awvalid_i
  , output logic                             s_axi_awready_o

  , input  logic [axi_data_width_p-1:0]      s_axi_wdata_i
  , input  logic [(axi_data_width_p>>3)-1:0] s_axi_wstrb_i
  , input  logic                             s_axi_wvalid_i
  , output logic                             s_axi_wready_o

  , output store_pkg::axi_resp_e             s_axi_bresp_o
  , output logic                             s_axi_bvalid_o
  , input  logic                             s_axi_bready_i

  , input  logic [axi_addr_width_p-1:0]      s_axi_araddr_i
  , input  store_pkg::axi_prot_e             s_axi_arprot_i
  , input  logic                             s_axi_arvalid_i
  , output logic                             s_axi_arready_o

  , output logic [axi_data_width_p-1:0]      s_axi_rdata_o
  , output store_pkg::axi_resp_e             s_axi_rresp_o
  , output logic                             s_axi_rvalid_o
  , input  logic                             s_axi_rready_i
  );

  import store_pkg::*;

  // Packer to command queue
  store_cmd_s cmd;
  logic       cmd_v;
  logic       cmd_ready;

  // Command queue to memory
  store_cmd_s mem_cmd;
  logic       mem_cmd_v;
  logic       mem_cmd_ready;

  // Memory to response queue
  store_rsp_s mem_rsp;
  logic       mem_rsp_v;
  logic       mem_rsp_ready;

  // Response queue to packer
  store_rsp_s rsp;
  logic       rsp_v;
  logic       rsp_ready;

  axil_store_packer
    #(.axi_addr_width_p(axi_addr_width_p)
    , .axi_data_width_p(axi_data_width_p)
    )
    packer
    (.clk_i           (clk_i)
    , .reset_i        (reset_i)
    , .s_axi_awaddr_i (s_axi_awaddr_i)
    , .s_axi_awprot_i (s_axi_awprot_i)
    , .s_axi_awvalid_i(s_axi_awvalid_i)
    , .s_axi_awready_o(s_axi_awready_o)
    , .s_axi_wdata_i  (s_axi_wdata_i)
    , .s_axi_wstrb_i  (s_axi_wstrb_i)
    , .s_axi_wvalid_i (s_axi_wvalid_i)
    , .s_axi_wready_o (s_axi_wready_o)
    , .s_axi_bresp_o  (s_axi_bresp_o)
    , .s_axi_bvalid_o (s_axi_bvalid_o)
    , .s_axi_bready_i (s_axi_bready_i)
    , .s_axi_araddr_i (s_axi_araddr_i)
    , .s_axi_arprot_i (s_axi_arprot_i)
    , .s_axi_arvalid_i(s_axi_arvalid_i)
    , .s_axi_arready_o(s_axi_arready_o)
    , .s_axi_rdata_o  (s_axi_rdata_o)
    , .s_axi_rresp_o  (s_axi_rresp_o)
    , .s_axi_rvalid_o (s_axi_rvalid_o)
    , .s_axi_rready_i (s_axi_rready_i)
    , .cmd_o          (cmd)
    , .cmd_v_o        (cmd_v)
    , .cmd_ready_i    (cmd_ready)
    , .rsp_i          (rsp)
    , .rsp_v_i        (rsp_v)
    , .rsp_ready_o    (rsp_ready)
    );

  store_queue #(.payload_t(store_cmd_s)) cmd_queue
    (.clk_i   (clk_i)
    , .reset_i(reset_i)
    , .data_i (cmd)
    , .v_i    (cmd_v)
    , .ready_o(cmd_ready)
    , .data_o (mem_cmd)
    , .v_o    (mem_cmd_v)
    , .ready_i(mem_cmd_ready)
    );

  byte_store #(.mem_addr_width_p(mem_addr_width_p)) store
    (.clk_i       (clk_i)
    , .reset_i    (reset_i)
    , .cmd_i      (mem_cmd)
    , .cmd_v_i    (mem_cmd_v)
    , .cmd_ready_o(mem_cmd_ready)
    , .rsp_o      (mem_rsp)
    , .rsp_v_o    (mem_rsp_v)
    , .rsp_ready_i(mem_rsp_ready)
    );

  store_queue #(.payload_t(store_rsp_s)) rsp_queue
    (.clk_i   (clk_i)
    , .reset_i(reset_i)
    , .data_i (mem_rsp)
    , .v_i    (mem_rsp_v)
    , .ready_o(mem_rsp_ready)
    , .data_o (rsp)
    , .v_o    (rsp_v)
    , .ready_i(rsp_ready)
    );

endmodule

/* source/byte_store.sv */
//##########################################################################
// Byte memory
// Executes packed commands, writes at once and returns read bytes
//##########################################################################

`timescale 1ns/1ps

module byte_store
  #(parameter int mem_addr_width_p = 8
  )
  (input  logic                   clk_i
  , input  logic                  reset_i

  , input  store_pkg::store_cmd_s cmd_i
  , input  logic                  cmd_v_i
  , output logic                  cmd_ready_o

  , output store_pkg::store_rsp_s rsp_o
  , output logic                  rsp_v_o
  , input  logic                  rsp_ready_i
  );

  import store_pkg::*;

  localparam int depth_lp = 2**mem_addr_width_p;

  logic [7:0] mem_r [depth_lp];

  store_rsp_s rsp_r;
  logic       rsp_v_r;
  logic       cmd_fire;
  logic [mem_addr_width_p-1:0] idx;

  // Upper address bits alias onto the same bytes
  assign idx = cmd_i.addr[mem_addr_width_p-1:0];

  // Stall only while an untaken read response sits here
  assign cmd_ready_o = ~rsp_v_r | rsp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  assign rsp_o   = rsp_r;
  assign rsp_v_o = rsp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < depth_lp; i++)
      begin
        mem_r[i] <= 8'h00;
      end
    end
    else if (cmd_fire & cmd_i.write_not_read)
    begin
      mem_r[idx] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire & ~cmd_i.write_not_read)
    begin
      rsp_r.data <= mem_r[idx];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_v_r <= 1'b0;
    end
    else if (cmd_fire & ~cmd_i.write_not_read)
    begin
      rsp_v_r <= 1'b1;
    end
    else if (rsp_ready_i)
    begin
      rsp_v_r <= 1'b0;
    end
  end

endmodule

/* source/store_queue.sv */
//##########################################################################
// Two-entry valid/ready FIFO
// Circular buffer with registered output, used for commands and responses
//##########################################################################

`timescale 1ns/1ps

module store_queue
  #(parameter type payload_t = logic [31:0]
  )
  (input  logic     clk_i
  , input  logic    reset_i

  , input  payload_t data_i
  , input  logic     v_i
  , output logic     ready_o

  , output payload_t data_o
  , output logic     v_o
  , input  logic     ready_i
  );

  payload_t mem_r [2];

  logic wptr_r;
  logic rptr_r;
  logic full_r;
  logic empty_r;
  logic enq;
  logic deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = v_o & ready_i;

  // Storage holds payload only
  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      wptr_r <= wptr_r ^ enq;
      rptr_r <= rptr_r ^ deq;
      // Simultaneous push and pop keeps the occupancy
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

endmodule

/* sources.f */
common/store_pkg.sv
store_packer/axil_store_packer.sv
source/store_queue.sv
source/byte_store.sv
source/axil_byte_bridge.sv
sim/axil_bridge_sva.sv
sim/tb_axil_byte_bridge.sv

/* store_packer/axil_store_packer.sv */
//##########################################################################
// AXI4-Lite store packer
// Packs one AXI4-Lite load or store at a time into a 32-bit command and
// answers with the matching OKAY response
//##########################################################################

`timescale 1ns/1ps

module axil_store_packer
  #(parameter int axi_addr_width_p = 32
  , parameter int axi_data_width_p = 32
  )
  (input  logic                                clk_i
  , input  logic                               reset_i

  // Write address
  , input  logic [axi_addr_width_p-1:0]        s_axi_awaddr_i
  , input  store_pkg::axi_prot_e               s_axi_awprot_i
  , input  logic                               s_axi_awvalid_i
  , output logic                               s_axi_awready_o

  // Write data
  , input  logic [axi_data_width_p-1:0]        s_axi_wdata_i
  , input  logic [(axi_data_width_p>>3)-1:0]   s_axi_wstrb_i
  , input  logic                               s_axi_wvalid_i
  , output logic                               s_axi_wready_o

  // Write response
  , output store_pkg::axi_resp_e               s_axi_bresp_o
  , output logic                               s_axi_bvalid_o
  , input  logic                               s_axi_bready_i

  // Read address
  , input  logic [axi_addr_width_p-1:0]        s_axi_araddr_i
  , input  store_pkg::axi_prot_e               s_axi_arprot_i
  , input  logic                               s_axi_arvalid_i
  , output logic                               s_axi_arready_o

  // Read data
  , output logic [axi_data_width_p-1:0]        s_axi_rdata_o
  , output store_pkg::axi_resp_e               s_axi_rresp_o
  , output logic                               s_axi_rvalid_o
  , input  logic                               s_axi_rready_i

  // Command channel toward the memory
  , output store_pkg::store_cmd_s              cmd_o
  , output logic                               cmd_v_o
  , input  logic                               cmd_ready_i

  // Response channel from the memory
  , input  store_pkg::store_rsp_s              rsp_i
  , input  logic                               rsp_v_i
  , output logic                               rsp_ready_o
  );

  import store_pkg::*;

  typedef enum logic [1:0] {e_idle, e_read_resp, e_write_resp} state_e;

  state_e state_r, state_n;

  logic is_idle;
  logic is_read_resp;
  logic is_write_resp;
  logic wr_req;
  logic rd_req;
  logic cmd_fire;

  assign is_idle       = (state_r == e_idle);
  assign is_read_resp  = (state_r == e_read_resp);
  assign is_write_resp = (state_r == e_write_resp);

  // Prot and strobes are accepted and ignored
  // Write needs both address and data present
  assign wr_req = s_axi_awvalid_i & s_axi_wvalid_i;
  assign rd_req = s_axi_arvalid_i;

  // Accept only when idle and the command queue has room
  assign s_axi_awready_o = is_idle & cmd_ready_i;
  assign s_axi_wready_o  = is_idle & cmd_ready_i;
  assign s_axi_arready_o = is_idle & cmd_ready_i;

  // Pack the request, read wins if both were ever seen
  assign cmd_o.write_not_read = ~rd_req;
  assign cmd_o.addr = rd_req ? s_axi_araddr_i[store_addr_width_c-1:0]
                             : s_axi_awaddr_i[store_addr_width_c-1:0];
  assign cmd_o.data = rd_req ? 8'h00 : s_axi_wdata_i[7:0];

  assign cmd_v_o  = is_idle & (wr_req | rd_req);
  assign cmd_fire = cmd_v_o & cmd_ready_i;

  // No error responses
  assign s_axi_bresp_o = e_axi_resp_okay;
  assign s_axi_rresp_o = e_axi_resp_okay;

  assign s_axi_bvalid_o = is_write_resp;
  assign s_axi_rvalid_o = is_read_resp & rsp_v_i;
  assign s_axi_rdata_o  = {{(axi_data_width_p-8){1'b0}}, rsp_i.data};
  assign rsp_ready_o    = s_axi_rready_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
      begin
        if (cmd_fire)
        begin
          state_n = rd_req ? e_read_resp : e_write_resp;
        end
      end
      e_read_resp:
      begin
        if (s_axi_rvalid_o & s_axi_rready_i)
        begin
          state_n = e_idle;
        end
      end
      e_write_resp:
      begin
        if (s_axi_bready_i)
        begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule
